/* Bender.yml */
package:
  name: mcu_cmd

export_include_dirs:
  - include

sources:
  - logic/mcu_cmd_pkg.sv
  - logic/mem_cfg_regs.sv
  - logic/mcu_mem_port.sv
  - logic/dac_ctrl.sv
  - logic/spi_readback.sv
  - logic/mcu_cmd_top.sv
  - target: test
    files:
      - verif/tb_mcu_cmd.sv

/* files.f */
+incdir+include
logic/mcu_cmd_pkg.sv
logic/mem_cfg_regs.sv
logic/mcu_mem_port.sv
logic/dac_ctrl.sv
logic/spi_readback.sv
logic/mcu_cmd_top.sv
verif/tb_mcu_cmd.sv

/* include/mcu_cmd_params.svh */
`ifndef MCU_CMD_PARAMS_SVH
`define MCU_CMD_PARAMS_SVH

// widths
`define MCU_BYTE_W      8
`define MCU_ADDR_W      24
`define MCU_MAPPER_W    3
`define MCU_SPI_CNT_W   32
`define DAC_PTR_W       9
`define DAC_VOL_W       3

// reset and constant values
`define MCU_MAPPER_RST  3'd1
`define MCU_SIGNATURE   8'hA5

// command groups, upper nibble of the command byte
`define MCU_CMD_ADDR      4'h0
`define MCU_CMD_ROM_MASK  4'h1
`define MCU_CMD_SAVERAM   4'h2
`define MCU_CMD_MAPPER    4'h3
`define MCU_CMD_MEM_RD    4'h8
`define MCU_CMD_MEM_WR    4'h9

// single opcodes
`define MCU_CMD_DAC_PAUSE   8'hE1
`define MCU_CMD_DAC_RESUME  8'hE2
`define MCU_CMD_DAC_PTR     8'hE3
`define MCU_CMD_DAC_PROP    8'hEC
`define MCU_CMD_SIGNATURE   8'hF0
`define MCU_CMD_STATUS      8'hF1
`define MCU_CMD_ECHO        8'hFF

`endif

/* logic/dac_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_params.svh"

module dac_ctrl import mcu_cmd_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  spi_cmd_t spi,
  output dac_cfg_t dac
);

  ////////////////////////////////////////
  // playback control from param bytes
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      dac.play       <= 1'b0;
      dac.reset      <= 1'b0;
      dac.vol_select <= '0;
      dac.palmode    <= 1'b0;
      dac.ptr        <= '0;
    end else begin
      dac.reset <= 1'b0;
      if (spi.param_ready) begin
        case (spi.cmd)
          `MCU_CMD_DAC_PAUSE:  dac.play <= 1'b0;
          `MCU_CMD_DAC_RESUME: dac.play <= 1'b1;
          `MCU_CMD_DAC_PTR: begin
            case (spi.byte_cnt)
              32'd2: dac.ptr[`DAC_PTR_W-1] <= spi.param[0];
              32'd3: begin
                // low byte completes the pointer and restarts playback
                dac.ptr[`MCU_BYTE_W-1:0] <= spi.param;
                dac.reset                <= 1'b1;
              end
              default: ;
            endcase
          end
          `MCU_CMD_DAC_PROP: begin
            dac.vol_select <= spi.param[`DAC_VOL_W-1:0];
            dac.palmode    <= spi.param[7];
          end
          default: ;
        endcase
      end
    end
  end

  a_rst_pulse: assert property (@(posedge clk) disable iff (reset)
    dac.reset |=> !dac.reset);

endmodule

`default_nettype wire

/* logic/mcu_cmd_pkg.sv */
`default_nettype none

`include "mcu_cmd_params.svh"

package mcu_cmd_pkg;

  // one SPI byte strobe with the decoded command context
  typedef struct packed {
    logic                        cmd_ready;
    logic                        param_ready;
    logic [`MCU_BYTE_W-1:0]      cmd;
    logic [`MCU_BYTE_W-1:0]      param;
    logic [`MCU_SPI_CNT_W-1:0]   byte_cnt;
  } spi_cmd_t;

  // memory map setup
  typedef struct packed {
    logic [`MCU_MAPPER_W-1:0]    mapper;
    logic [`MCU_ADDR_W-1:0]      rom_mask;
    logic [`MCU_ADDR_W-1:0]      saveram_mask;
    logic [`MCU_BYTE_W-1:0]      saveram_base;
  } mem_cfg_t;

  typedef struct packed {
    logic                        play;
    logic                        reset;
    logic [`DAC_VOL_W-1:0]       vol_select;
    logic                        palmode;
    logic [`DAC_PTR_W-1:0]       ptr;
  } dac_cfg_t;

  // valid is a single cycle pulse
  typedef struct packed {
    logic                        valid;
    logic [`MCU_BYTE_W-1:0]      data;
  } mem_rd_t;

endpackage

`default_nettype wire

/* logic/mcu_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_params.svh"

module mcu_cmd_top import mcu_cmd_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  spi_cmd_t               spi,
  input  logic                   mcu_rq_rdy,
  input  logic [`MCU_BYTE_W-1:0] mcu_data_in,
  input  logic                   dac_status,
  output logic                   mcu_rrq,
  output logic                   mcu_wrq,
  output logic [`MCU_BYTE_W-1:0] mcu_data_out,
  output logic [`MCU_ADDR_W-1:0] addr,
  output mem_cfg_t               mem_cfg,
  output dac_cfg_t               dac,
  output logic [`MCU_BYTE_W-1:0] spi_data_out
);

  mem_rd_t mem_rd;

  mem_cfg_regs u_mem_cfg_regs (
    .clk     (clk),
    .reset   (reset),
    .spi     (spi),
    .mem_cfg (mem_cfg)
  );

  mcu_mem_port u_mcu_mem_port (
    .clk          (clk),
    .reset        (reset),
    .spi          (spi),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .addr         (addr),
    .rd           (mem_rd)
  );

  dac_ctrl u_dac_ctrl (
    .clk   (clk),
    .reset (reset),
    .spi   (spi),
    .dac   (dac)
  );

  spi_readback u_spi_readback (
    .clk          (clk),
    .reset        (reset),
    .spi          (spi),
    .rd           (mem_rd),
    .dac_status   (dac_status),
    .spi_data_out (spi_data_out)
  );

endmodule

`default_nettype wire

/* logic/mcu_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_params.svh"

module mcu_mem_port import mcu_cmd_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  spi_cmd_t               spi,
  input  logic                   mcu_rq_rdy,
  input  logic [`MCU_BYTE_W-1:0] mcu_data_in,
  output logic                   mcu_rrq,
  output logic                   mcu_wrq,
  output logic [`MCU_BYTE_W-1:0] mcu_data_out,
  output logic [`MCU_ADDR_W-1:0] addr,
  output mem_rd_t                rd
);

  logic [`MCU_BYTE_W/2-1:0]   grp;
  logic                       rd_grp;
  logic                       wr_grp;
  logic                       addr_load;
  logic [1:0]                 rdy_sr;
  logic                       next_addr;
  logic [`MCU_SPI_CNT_W-1:0]  min_cnt;
  logic                       addr_inc;
  logic                       rd_valid;
  logic [`MCU_BYTE_W-1:0]     rd_data;

  assign grp    = spi.cmd[`MCU_BYTE_W-1:`MCU_BYTE_W/2];
  assign rd_grp = grp == `MCU_CMD_MEM_RD;
  assign wr_grp = grp == `MCU_CMD_MEM_WR;

  // sub-selects 01 and 10 belong to other pointers
  assign addr_load = spi.param_ready && grp == `MCU_CMD_ADDR &&
                     spi.cmd[1:0] != 2'b01 && spi.cmd[1:0] != 2'b10;

  ////////////////////////////////////////
  // ready edge detect
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      rdy_sr <= '0;
    end else begin
      rdy_sr <= {rdy_sr[0], mcu_rq_rdy};
    end
  end

  assign next_addr = rdy_sr == 2'b01;

  // bit 4 delays the first increment by one byte
  assign min_cnt  = {{(`MCU_SPI_CNT_W-1){1'b0}}, spi.cmd[4]} + 1'b1;
  assign addr_inc = next_addr && (rd_grp || wr_grp) && spi.cmd[3] &&
                    spi.byte_cnt >= min_cnt;

  ////////////////////////////////////////
  // address pointer
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      addr <= '0;
    end else if (addr_load) begin
      case (spi.byte_cnt)
        32'd2: addr <= {spi.param, {(`MCU_ADDR_W-`MCU_BYTE_W){1'b0}}};
        32'd3: addr[15:8] <= spi.param;
        32'd4: addr[7:0]  <= spi.param;
        default: ;
      endcase
    end else if (addr_inc) begin
      addr <= addr + 1'b1;
    end
  end

  // request pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      mcu_rrq  <= 1'b0;
      mcu_wrq  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      mcu_rrq  <= (spi.cmd_ready || spi.param_ready) && rd_grp;
      mcu_wrq  <= spi.param_ready && wr_grp;
      rd_valid <= next_addr && rd_grp;
    end
  end

  always_ff @(posedge clk) begin
    if (spi.param_ready && wr_grp) begin
      mcu_data_out <= spi.param;
    end
    if (next_addr && rd_grp) begin
      rd_data <= mcu_data_in;
    end
  end

  assign rd = '{valid: rd_valid, data: rd_data};

  a_rd_in_grp: assert property (@(posedge clk) disable iff (reset)
    rd_valid |-> rd_grp);

endmodule

`default_nettype wire

/* logic/mem_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_params.svh"

module mem_cfg_regs import mcu_cmd_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  spi_cmd_t spi,
  output mem_cfg_t mem_cfg
);

  logic [`MCU_BYTE_W/2-1:0] grp;

  assign grp = spi.cmd[`MCU_BYTE_W-1:`MCU_BYTE_W/2];

  ////////////////////////////////////////
  // mapper select on the command byte
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_cfg.mapper <= `MCU_MAPPER_RST;
    end else if (spi.cmd_ready && grp == `MCU_CMD_MAPPER) begin
      mem_cfg.mapper <= spi.cmd[`MCU_MAPPER_W-1:0];
    end
  end

  ////////////////////////////////////////
  // masks and base from parameter bytes
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_cfg.rom_mask     <= '0;
      mem_cfg.saveram_mask <= '0;
      mem_cfg.saveram_base <= '0;
    end else if (spi.param_ready) begin
      case (grp)
        `MCU_CMD_ROM_MASK: begin
          // sent high byte first
          case (spi.byte_cnt)
            32'd2: mem_cfg.rom_mask[23:16] <= spi.param;
            32'd3: mem_cfg.rom_mask[15:8]  <= spi.param;
            32'd4: mem_cfg.rom_mask[7:0]   <= spi.param;
            default: ;
          endcase
        end
        `MCU_CMD_SAVERAM: begin
          case (spi.byte_cnt)
            32'd2: begin
              // bit 0 picks base instead of mask
              if (spi.cmd[0]) begin
                mem_cfg.saveram_base <= spi.param;
              end else begin
                mem_cfg.saveram_mask[23:16] <= spi.param;
              end
            end
            32'd3: mem_cfg.saveram_mask[15:8] <= spi.param;
            32'd4: mem_cfg.saveram_mask[7:0]  <= spi.param;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/spi_readback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_params.svh"

module spi_readback import mcu_cmd_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  spi_cmd_t               spi,
  input  mem_rd_t                rd,
  input  logic                   dac_status,
  output logic [`MCU_BYTE_W-1:0] spi_data_out
);

  logic dac_status_q;
  logic strobe;

  assign strobe = spi.cmd_ready || spi.param_ready;

  // async status from the DAC side
  always_ff @(posedge clk) begin
    if (reset) begin
      dac_status_q <= 1'b0;
    end else begin
      dac_status_q <= dac_status;
    end
  end

  ////////////////////////////////////////
  // byte returned on the next transfer
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      spi_data_out <= '0;
    end else if (rd.valid) begin
      // memory data wins over any strobe
      spi_data_out <= rd.data;
    end else if (strobe) begin
      case (spi.cmd)
        `MCU_CMD_SIGNATURE: spi_data_out <= `MCU_SIGNATURE;
        `MCU_CMD_STATUS:    spi_data_out <= {1'b0, dac_status_q, 6'b0};
        `MCU_CMD_ECHO:      spi_data_out <= spi.param;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verif/tb_mcu_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_params.svh"

module tb_mcu_cmd import mcu_cmd_pkg::*;;

  localparam logic [`MCU_BYTE_W-1:0] MODEL_XOR = 8'h5c;

  logic                   clk;
  logic                   reset;
  spi_cmd_t               spi;
  logic                   mcu_rq_rdy;
  logic [`MCU_BYTE_W-1:0] mcu_data_in;
  logic                   dac_status;
  logic                   mcu_rrq;
  logic                   mcu_wrq;
  logic [`MCU_BYTE_W-1:0] mcu_data_out;
  logic [`MCU_ADDR_W-1:0] addr;
  mem_cfg_t               mem_cfg;
  dac_cfg_t               dac;
  logic [`MCU_BYTE_W-1:0] spi_data_out;

  int          value_errs;
  int          timeout_errs;
  int          rdy_count;
  logic [31:0] rand_state;
  mem_cfg_t    exp_cfg;
  dac_cfg_t    exp_dac;

  mcu_cmd_top UUT (
    .clk          (clk),
    .reset        (reset),
    .spi          (spi),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .dac_status   (dac_status),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .addr         (addr),
    .mem_cfg      (mem_cfg),
    .dac          (dac),
    .spi_data_out (spi_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////
  assign mcu_data_in = addr[`MCU_BYTE_W-1:0] ^ MODEL_XOR;

  initial begin : mem_model
    int delay;
    mcu_rq_rdy = 1'b0;
    rdy_count  = 0;
    rand_state = 32'h0aa2_9c0c;
    forever begin
      @(posedge clk);
      #1;
      if (mcu_rrq === 1'b1 || mcu_wrq === 1'b1) begin
        rand_state = next_rand(rand_state);
        delay = 1 + rand_state[17:16];
        repeat (delay) @(posedge clk);
        #1;
        mcu_rq_rdy = 1'b1;
        @(posedge clk);
        #1;
        mcu_rq_rdy = 1'b0;
        rdy_count++;
      end
    end
  end

  ////////////////////////////////////////
  // drive and wait tasks
  ////////////////////////////////////////
  task automatic send_cmd(input logic [`MCU_BYTE_W-1:0] c);
    @(posedge clk);
    #1;
    spi.cmd       = c;
    spi.byte_cnt  = 1;
    spi.cmd_ready = 1'b1;
    @(posedge clk);
    #1;
    spi.cmd_ready = 1'b0;
  endtask

  task automatic send_param(input logic [`MCU_BYTE_W-1:0] p);
    @(posedge clk);
    #1;
    spi.param       = p;
    spi.byte_cnt    = spi.byte_cnt + 1;
    spi.param_ready = 1'b1;
    @(posedge clk);
    #1;
    spi.param_ready = 1'b0;
  endtask

  task automatic load_addr(input logic [`MCU_ADDR_W-1:0] a);
    send_cmd({`MCU_CMD_ADDR, 4'h0});
    send_param(a[23:16]);
    send_param(a[15:8]);
    send_param(a[7:0]);
  endtask

  task automatic wait_request(input logic write);
    int n;
    n = 0;
    while ((write ? mcu_wrq : mcu_rrq) !== 1'b1 && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    if ((write ? mcu_wrq : mcu_rrq) !== 1'b1) begin
      $display("memory %s request did not arrive within 50 cycles",
               write ? "write" : "read");
      timeout_errs++;
    end
  endtask

  task automatic wait_ready_done(input int start);
    int n;
    n = 0;
    while (rdy_count == start && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (rdy_count == start) begin
      $display("memory model never answered a request within 50 cycles");
      timeout_errs++;
    end
    // next-address event trails the ready edge by two cycles
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic wait_byte_change(input logic [`MCU_BYTE_W-1:0] prev);
    int n;
    n = 0;
    while (spi_data_out === prev && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (spi_data_out === prev) begin
      $display("read data never showed up on spi_data_out within 50 cycles");
      timeout_errs++;
    end
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_byte(input string name, input logic [`MCU_BYTE_W-1:0] exp,
                            input logic [`MCU_BYTE_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_addr(input logic [`MCU_ADDR_W-1:0] exp,
                            input logic [`MCU_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] addr expected %h got %h", exp, act);
      value_errs++;
    end
  endtask

  task automatic check_mem_cfg(input mem_cfg_t exp, input mem_cfg_t act);
    if (act !== exp) begin
      $display("[ERROR] mem_cfg expected %h got %h", exp, act);
      value_errs++;
    end
  endtask

  task automatic check_dac(input dac_cfg_t exp, input dac_cfg_t act);
    if (act !== exp) begin
      $display("[ERROR] dac expected %h got %h", exp, act);
      value_errs++;
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic reset_values();
    exp_cfg        = '0;
    exp_cfg.mapper = `MCU_MAPPER_RST;
    exp_dac        = '0;
    check_mem_cfg(exp_cfg, mem_cfg);
    check_dac(exp_dac, dac);
    check_addr('0, addr);
    check_byte("spi_data_out", '0, spi_data_out);
    check_bit("mcu_rrq", 1'b0, mcu_rrq);
    check_bit("mcu_wrq", 1'b0, mcu_wrq);
  endtask

  task automatic config_regs();
    send_cmd({`MCU_CMD_MAPPER, 4'h5});
    exp_cfg.mapper = 3'd5;
    check_mem_cfg(exp_cfg, mem_cfg);
    send_cmd({`MCU_CMD_ROM_MASK, 4'h0});
    send_param(8'h3f);
    send_param(8'hff);
    send_param(8'hff);
    exp_cfg.rom_mask = 24'h3f_ffff;
    check_mem_cfg(exp_cfg, mem_cfg);
    send_cmd({`MCU_CMD_SAVERAM, 4'h0});
    send_param(8'h00);
    send_param(8'h1f);
    send_param(8'hff);
    exp_cfg.saveram_mask = 24'h00_1fff;
    check_mem_cfg(exp_cfg, mem_cfg);
    // bit 0 set, first byte is the base
    send_cmd({`MCU_CMD_SAVERAM, 4'h1});
    send_param(8'h60);
    exp_cfg.saveram_base = 8'h60;
    check_mem_cfg(exp_cfg, mem_cfg);
  endtask

  task automatic read_stream();
    logic [`MCU_ADDR_W-1:0] exp_addr;
    logic [`MCU_BYTE_W-1:0] prev;
    exp_addr = 24'h12_3456;
    load_addr(exp_addr);
    check_addr(exp_addr, addr);
    // command byte plus four dummy params, one access each
    for (int i = 0; i < 5; i++) begin
      prev = spi_data_out;
      if (i == 0) begin
        send_cmd(8'h88);
      end else begin
        send_param(8'h10 + i[7:0]);
      end
      wait_request(1'b0);
      wait_byte_change(prev);
      check_byte("spi_data_out", exp_addr[7:0] ^ MODEL_XOR, spi_data_out);
      exp_addr = exp_addr + 1;
      check_addr(exp_addr, addr);
    end
  endtask

  task automatic write_stream();
    logic [`MCU_ADDR_W-1:0] exp_addr;
    logic [`MCU_BYTE_W-1:0] d;
    int                     start;
    exp_addr = 24'h00_8010;
    load_addr(exp_addr);
    send_cmd(8'h98);
    for (int i = 0; i < 3; i++) begin
      d     = 8'ha1 + i[7:0] * 8'h3b;
      start = rdy_count;
      send_param(d);
      wait_request(1'b1);
      check_byte("mcu_data_out", d, mcu_data_out);
      wait_ready_done(start);
      exp_addr = exp_addr + 1;
      check_addr(exp_addr, addr);
    end
    // no bit 3, pointer holds
    send_cmd(8'h90);
    for (int i = 0; i < 2; i++) begin
      d     = 8'h11 * (i[7:0] + 8'd1);
      start = rdy_count;
      send_param(d);
      wait_request(1'b1);
      check_byte("mcu_data_out", d, mcu_data_out);
      wait_ready_done(start);
      check_addr(exp_addr, addr);
    end
  endtask

  task automatic dac_control();
    int pulses;
    send_cmd(`MCU_CMD_DAC_RESUME);
    send_param(8'h00);
    exp_dac.play = 1'b1;
    check_dac(exp_dac, dac);
    send_cmd(`MCU_CMD_DAC_PAUSE);
    send_param(8'h00);
    exp_dac.play = 1'b0;
    check_dac(exp_dac, dac);
    send_cmd(`MCU_CMD_DAC_PROP);
    send_param(8'h85);
    exp_dac.vol_select = 3'd5;
    exp_dac.palmode    = 1'b1;
    check_dac(exp_dac, dac);
    send_cmd(`MCU_CMD_DAC_PTR);
    send_param(8'h01);
    exp_dac.ptr = 9'h100;
    check_dac(exp_dac, dac);
    send_param(8'h7f);
    exp_dac.ptr   = 9'h17f;
    exp_dac.reset = 1'b1;
    check_dac(exp_dac, dac);
    pulses = (dac.reset === 1'b1) ? 1 : 0;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      if (dac.reset === 1'b1) begin
        pulses++;
      end
    end
    exp_dac.reset = 1'b0;
    check_dac(exp_dac, dac);
    if (pulses != 1) begin
      $display("[ERROR] dac.reset pulse count expected %h got %h", 1, pulses);
      value_errs++;
    end
  endtask

  task automatic readback_bytes();
    send_cmd(`MCU_CMD_SIGNATURE);
    check_byte("spi_data_out", 8'ha5, spi_data_out);
    send_cmd(`MCU_CMD_ECHO);
    send_param(8'h3c);
    check_byte("spi_data_out", 8'h3c, spi_data_out);
    send_param(8'hc3);
    check_byte("spi_data_out", 8'hc3, spi_data_out);
    send_param(8'h00);
    check_byte("spi_data_out", 8'h00, spi_data_out);
    @(posedge clk);
    #1;
    dac_status = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    send_cmd(`MCU_CMD_STATUS);
    check_byte("spi_data_out", 8'h40, spi_data_out);
    dac_status = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    send_cmd(`MCU_CMD_STATUS);
    check_byte("spi_data_out", 8'h00, spi_data_out);
  endtask

  initial begin
    value_errs   = 0;
    timeout_errs = 0;
    reset        = 1'b1;
    spi          = '0;
    dac_status   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_values();
    config_regs();
    read_stream();
    write_stream();
    dac_control();
    readback_bytes();
    $display("errors: %0d value, %0d timeout", value_errs, timeout_errs);
    if (value_errs + timeout_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
